// ==== hw/aimbot_pkg.sv ====
package aimbot_pkg;

    localparam int pix_w      = 16; // one RGB565 pixel
    localparam int byte_w     = 8;  // camera data bus
    localparam int line_cnt_w = 12; // enough for a 1280 pixel line

    // byte pairing inside one camera line
    typedef enum logic {
        cap_high,
        cap_low
    } cap_state_t;

    // frame level state of the pixel path
    typedef enum logic [1:0] {
        st_idle,
        st_sync,
        st_run,
        st_fault
    } stream_state_t;

endpackage : aimbot_pkg

// ==== hw/rgb565_capture.sv ====
module rgb565_capture (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              cap_en,
    input  logic                              href,
    input  logic [aimbot_pkg::byte_w-1:0]     data,
    output logic [aimbot_pkg::pix_w-1:0]      pix,
    output logic                              pix_valid,
    output logic                              line_end,
    output logic [aimbot_pkg::line_cnt_w-1:0] line_len
);

    aimbot_pkg::cap_state_t            state;
    logic [aimbot_pkg::byte_w-1:0]     hi_byte;
    logic [aimbot_pkg::line_cnt_w-1:0] pix_cnt;
    logic                              href_d;
    logic                              href_fall;
    logic                              take;

    assign take      = cap_en && href; // one byte per clock while this is high
    assign href_fall = href_d && !href;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= aimbot_pkg::cap_high;
            href_d    <= 1'b0;
            pix_valid <= 1'b0;
            line_end  <= 1'b0;
            pix_cnt   <= '0;
        end else begin
            href_d    <= href;
            pix_valid <= take && (state == aimbot_pkg::cap_low);
            line_end  <= href_fall && cap_en;
            if (!take) begin
                state <= aimbot_pkg::cap_high; // an odd byte left at line end is lost
            end else if (state == aimbot_pkg::cap_high) begin
                state <= aimbot_pkg::cap_low;
            end else begin
                state   <= aimbot_pkg::cap_high;
                pix_cnt <= pix_cnt + 1'b1;
            end
            if (href_fall) begin
                pix_cnt <= '0;
            end
        end
    end

    // the high byte comes first on the bus
    always_ff @(posedge clk) begin
        if (take && state == aimbot_pkg::cap_high) begin
            hi_byte <= data;
        end
        if (take && state == aimbot_pkg::cap_low) begin
            pix <= {hi_byte, data};
        end
        if (href_fall) begin
            line_len <= pix_cnt; // last pixel of the line is already counted here
        end
    end

    // a pixel only leaves while capture is enabled
    a_valid_needs_en : assert property (
        @(posedge clk) disable iff (rst)
        pix_valid |-> cap_en
    );

endmodule : rgb565_capture

// ==== hw/line_fifo.sv ====
module line_fifo #(
    parameter int fifo_depth = 16
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         flush,
    input  logic                         wr,
    input  logic [aimbot_pkg::pix_w-1:0] wdata,
    input  logic                         rd,
    output logic [aimbot_pkg::pix_w-1:0] rdata,
    output logic                         empty,
    output logic                         full,
    output logic                         overflow
);

    localparam int addr_w = $clog2(fifo_depth);

    logic [aimbot_pkg::pix_w-1:0] mem [fifo_depth];
    logic [addr_w-1:0]            wr_ptr;
    logic [addr_w-1:0]            rd_ptr;
    logic [addr_w:0]              count;
    logic                         do_wr;
    logic                         do_rd;

    assign empty = (count == '0);
    assign full  = (count == (addr_w + 1)'(fifo_depth));
    assign do_wr = wr && !full && !flush;
    assign do_rd = rd && !empty && !flush;
    assign rdata = mem[rd_ptr]; // head word is visible while not empty

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            overflow <= wr && full; // the incoming pixel is dropped
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wdata;
        end
    end

    // the reader must look at empty before popping
    a_no_rd_empty : assert property (
        @(posedge clk) disable iff (rst)
        rd |-> !empty
    );

endmodule : line_fifo

// ==== hw/pixel_combine.sv ====
module pixel_combine (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              run,
    input  logic                              flush,
    input  logic [aimbot_pkg::pix_w-1:0]      rdata_1,
    input  logic [aimbot_pkg::pix_w-1:0]      rdata_2,
    input  logic                              empty_1,
    input  logic                              empty_2,
    input  logic                              overflow_1,
    input  logic                              overflow_2,
    input  logic                              line_end_1,
    input  logic                              line_end_2,
    input  logic [aimbot_pkg::line_cnt_w-1:0] line_len_1,
    input  logic [aimbot_pkg::line_cnt_w-1:0] line_len_2,
    output logic                              rd,
    output logic [aimbot_pkg::pix_w-1:0]      pixel_1,
    output logic [aimbot_pkg::pix_w-1:0]      pixel_2,
    output logic                              valid,
    output logic                              fault
);

    logic [aimbot_pkg::line_cnt_w-1:0] pend_len;
    logic [aimbot_pkg::line_cnt_w-1:0] new_len;
    logic                              pend;
    logic                              pend_src; // low for cam1, high for cam2
    logic                              pend_nxt;
    logic                              mismatch;

    // both pixels of a pair leave together
    assign rd      = run && !empty_1 && !empty_2;
    assign new_len = line_end_1 ? line_len_1 : line_len_2;

    always_comb begin
        mismatch = 1'b0;
        pend_nxt = pend;
        if (line_end_1 && line_end_2) begin
            mismatch = pend || (line_len_1 != line_len_2);
            pend_nxt = 1'b0;
        end else if (line_end_1 || line_end_2) begin
            if (!pend) begin
                pend_nxt = 1'b1;
            end else if (pend_src != line_end_2) begin
                mismatch = (pend_len != new_len);
                pend_nxt = 1'b0;
            end else begin
                // same camera ended twice, so the other one lost a line
                mismatch = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= 1'b0;
            fault <= 1'b0;
            pend  <= 1'b0;
        end else begin
            valid <= rd;
            fault <= overflow_1 || overflow_2 || (mismatch && !flush);
            pend  <= pend_nxt && !flush;
        end
    end

    always_ff @(posedge clk) begin
        if (rd) begin
            pixel_1 <= rdata_1;
            pixel_2 <= rdata_2;
        end
        if ((line_end_1 || line_end_2) && !pend) begin
            pend_len <= new_len;
            pend_src <= line_end_2;
        end else if (line_end_1 != line_end_2 && pend && pend_src == line_end_2) begin
            pend_len <= new_len; // keep the newest length of the repeating camera
        end
    end

    a_no_valid_stopped : assert property (
        @(posedge clk) disable iff (rst)
        !run |=> !valid
    );

endmodule : pixel_combine

// ==== hw/hsync_gen.sv ====
module hsync_gen #(
    parameter int hs_after = 5,
    parameter int hs_hold  = 5
) (
    input  logic clk,
    input  logic rst,
    input  logic href,
    output logic hsync
);

    localparam int               cnt_w  = $clog2(hs_after + hs_hold + 1);
    localparam logic [cnt_w-1:0] on_at  = cnt_w'(hs_after);
    localparam logic [cnt_w-1:0] off_at = cnt_w'(hs_after + hs_hold);

    logic [cnt_w-1:0] cnt; // cycles since the last falling edge of href
    logic             active;
    logic             href_d;
    logic             href_fall;

    assign href_fall = href_d && !href;
    assign hsync     = active && (cnt >= on_at);

    always_ff @(posedge clk) begin
        if (rst) begin
            href_d <= 1'b0;
            active <= 1'b0;
            cnt    <= '0;
        end else begin
            href_d <= href;
            if (href_fall) begin
                active <= 1'b1; // restarts a count already running
                cnt    <= cnt_w'(1);
            end else if (active) begin
                if (cnt == off_at - 1'b1) begin
                    active <= 1'b0;
                end
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule : hsync_gen

// ==== hw/stream_ctrl.sv ====
module stream_ctrl (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      en,
    input  logic                      vsync_1,
    input  logic                      vsync_2,
    input  logic                      fault,
    output logic                      cap_en,
    output logic                      flush,
    output logic                      run,
    output aimbot_pkg::stream_state_t state
);

    aimbot_pkg::stream_state_t state_nxt;
    logic                      vs_both;
    logic                      vs_both_d;
    logic                      vs_rise;

    assign vs_both = vsync_1 && vsync_2;
    assign vs_rise = vs_both && !vs_both_d;

    // capture and readout only while a frame is running
    assign cap_en = (state == aimbot_pkg::st_run);
    assign run    = (state == aimbot_pkg::st_run);

    always_comb begin
        state_nxt = state;
        flush     = 1'b0;
        case (state)
            aimbot_pkg::st_idle: begin
                if (en) begin
                    state_nxt = aimbot_pkg::st_sync;
                end
            end
            aimbot_pkg::st_sync: begin
                if (vs_both) begin
                    flush     = 1'b1;
                    state_nxt = aimbot_pkg::st_run;
                end
            end
            aimbot_pkg::st_run: begin
                if (fault) begin
                    state_nxt = aimbot_pkg::st_fault;
                end
            end
            aimbot_pkg::st_fault: begin
                // wait for a fresh frame start from both sensors
                if (vs_rise) begin
                    flush     = 1'b1;
                    state_nxt = aimbot_pkg::st_run;
                end
            end
            default: state_nxt = aimbot_pkg::st_idle;
        endcase
        if (!en) begin
            state_nxt = aimbot_pkg::st_idle;
            flush     = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= aimbot_pkg::st_idle;
            vs_both_d <= 1'b0;
        end else begin
            state     <= state_nxt;
            vs_both_d <= vs_both;
        end
    end

    a_flush_enters_run : assert property (
        @(posedge clk) disable iff (rst)
        flush |=> (state == aimbot_pkg::st_run)
    );

endmodule : stream_ctrl

// ==== hw/aimbot_vision.sv ====
module aimbot_vision #(
    parameter int fifo_depth = 16,
    parameter int hs_after   = 5,
    parameter int hs_hold    = 5
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          en,
    input  logic                          cam1_vsync,
    input  logic                          cam1_href,
    input  logic [aimbot_pkg::byte_w-1:0] cam1_data,
    input  logic                          cam2_vsync,
    input  logic                          cam2_href,
    input  logic [aimbot_pkg::byte_w-1:0] cam2_data,
    output logic                          hdmi_de,
    output logic [7:0]                    hdmi_r,
    output logic [7:0]                    hdmi_g,
    output logic [7:0]                    hdmi_b,
    output logic                          hdmi_hsync,
    output logic                          hdmi_vsync,
    output logic [aimbot_pkg::pix_w-1:0]  pix2,
    output logic                          comb_err,
    output aimbot_pkg::stream_state_t     state
);

    logic [aimbot_pkg::pix_w-1:0]      cam1_pix, cam2_pix;
    logic                              cam1_pix_valid, cam2_pix_valid;
    logic                              cam1_line_end, cam2_line_end;
    logic [aimbot_pkg::line_cnt_w-1:0] cam1_line_len, cam2_line_len;
    logic [aimbot_pkg::pix_w-1:0]      fifo1_rdata, fifo2_rdata;
    logic                              fifo1_empty, fifo2_empty;
    logic                              fifo1_overflow, fifo2_overflow;
    logic [aimbot_pkg::pix_w-1:0]      comb_pix_1, comb_pix_2;
    logic                              comb_rd;
    logic                              comb_valid;
    logic                              comb_fault;
    logic                              cap_en;
    logic                              flush;
    logic                              run;

    rgb565_capture u_cam1_capture (
        .clk      (clk           ),
        .rst      (rst           ),
        .cap_en   (cap_en        ),
        .href     (cam1_href     ),
        .data     (cam1_data     ),
        .pix      (cam1_pix      ),
        .pix_valid(cam1_pix_valid),
        .line_end (cam1_line_end ),
        .line_len (cam1_line_len )
    );

    rgb565_capture u_cam2_capture (
        .clk      (clk           ),
        .rst      (rst           ),
        .cap_en   (cap_en        ),
        .href     (cam2_href     ),
        .data     (cam2_data     ),
        .pix      (cam2_pix      ),
        .pix_valid(cam2_pix_valid),
        .line_end (cam2_line_end ),
        .line_len (cam2_line_len )
    );

    // the line buffers soak up the skew between the two sensors
    line_fifo #(.fifo_depth(fifo_depth)) u_cam1_fifo (
        .clk     (clk           ),
        .rst     (rst           ),
        .flush   (flush         ),
        .wr      (cam1_pix_valid),
        .wdata   (cam1_pix      ),
        .rd      (comb_rd       ),
        .rdata   (fifo1_rdata   ),
        .empty   (fifo1_empty   ),
        .full    (              ),
        .overflow(fifo1_overflow)
    );

    line_fifo #(.fifo_depth(fifo_depth)) u_cam2_fifo (
        .clk     (clk           ),
        .rst     (rst           ),
        .flush   (flush         ),
        .wr      (cam2_pix_valid),
        .wdata   (cam2_pix      ),
        .rd      (comb_rd       ),
        .rdata   (fifo2_rdata   ),
        .empty   (fifo2_empty   ),
        .full    (              ),
        .overflow(fifo2_overflow)
    );

    pixel_combine u_pixel_combine (
        .clk       (clk           ),
        .rst       (rst           ),
        .run       (run           ),
        .flush     (flush         ),
        .rdata_1   (fifo1_rdata   ),
        .rdata_2   (fifo2_rdata   ),
        .empty_1   (fifo1_empty   ),
        .empty_2   (fifo2_empty   ),
        .overflow_1(fifo1_overflow),
        .overflow_2(fifo2_overflow),
        .line_end_1(cam1_line_end ),
        .line_end_2(cam2_line_end ),
        .line_len_1(cam1_line_len ),
        .line_len_2(cam2_line_len ),
        .rd        (comb_rd       ),
        .pixel_1   (comb_pix_1    ),
        .pixel_2   (comb_pix_2    ),
        .valid     (comb_valid    ),
        .fault     (comb_fault    )
    );

    hsync_gen #(.hs_after(hs_after), .hs_hold(hs_hold)) u_hsync_gen (
        .clk  (clk       ),
        .rst  (rst       ),
        .href (cam1_href ),
        .hsync(hdmi_hsync)
    );

    stream_ctrl u_stream_ctrl (
        .clk    (clk       ),
        .rst    (rst       ),
        .en     (en        ),
        .vsync_1(cam1_vsync),
        .vsync_2(cam2_vsync),
        .fault  (comb_fault),
        .cap_en (cap_en    ),
        .flush  (flush     ),
        .run    (run       ),
        .state  (state     )
    );

    assign comb_err   = (state == aimbot_pkg::st_fault);
    assign hdmi_vsync = cam1_vsync;

    always_ff @(posedge clk) begin
        if (rst) begin
            hdmi_de <= 1'b0;
        end else begin
            hdmi_de <= comb_valid; // lines up with the registered colors
        end
    end

    // 565 fields widened to 8 bits with zeros in the low bits
    always_ff @(posedge clk) begin
        hdmi_r <= {comb_pix_1[15:11], 3'b000};
        hdmi_g <= {comb_pix_1[10:5], 2'b00};
        hdmi_b <= {comb_pix_1[4:0], 3'b000};
        pix2   <= comb_pix_2;
    end

endmodule : aimbot_vision

// ==== tb/tb_aimbot_vision.sv ====
module tb_aimbot_vision;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int fifo_depth = 16; // same values as the DUT defaults
    localparam int hs_after   = 5;
    localparam int hs_hold    = 5;
    localparam int hs_span    = hs_after + hs_hold;

    localparam int n_frames    = 6;
    localparam int n_lines     = 3;
    localparam int max_pix     = 24;
    localparam int line_gap    = 30; // skew, idle gap and pipeline drain
    localparam int vs_time     = 60;
    localparam int cycle_limit = n_frames * (n_lines * (2 * max_pix + line_gap) + vs_time) + 200;

    localparam logic [4:0] idle_exp = {aimbot_pkg::st_idle, 3'b000};

    logic                          clk = 1'b0;
    logic                          rst;
    logic                          en;
    logic                          cam1_vsync;
    logic                          cam1_href;
    logic [aimbot_pkg::byte_w-1:0] cam1_data;
    logic                          cam2_vsync;
    logic                          cam2_href;
    logic [aimbot_pkg::byte_w-1:0] cam2_data;
    logic                          hdmi_de;
    logic [7:0]                    hdmi_r;
    logic [7:0]                    hdmi_g;
    logic [7:0]                    hdmi_b;
    logic                          hdmi_hsync;
    logic                          hdmi_vsync;
    logic [aimbot_pkg::pix_w-1:0]  pix2;
    logic                          comb_err;
    aimbot_pkg::stream_state_t     state;

    logic [15:0]        ref1 [$]; // pixels sent by cam1, oldest first
    logic [15:0]        ref2 [$];
    logic [15:0]        head1;
    logic [15:0]        head2;
    logic               have_ref;
    logic               idle_phase;
    logic               clean;
    logic               fault_check;
    logic               drain_check;
    int                 left1;
    int                 left2;
    int                 err_value;
    int                 err_other;
    int                 cycles;
    logic [31:0]        rnd;
    logic               href_q;
    logic [hs_span-1:0] fall_sr;
    logic               hs_exp;
    logic [4:0]         idle_obs;

    aimbot_vision u_aimbot_vision (
        .clk       (clk       ),
        .rst       (rst       ),
        .en        (en        ),
        .cam1_vsync(cam1_vsync),
        .cam1_href (cam1_href ),
        .cam1_data (cam1_data ),
        .cam2_vsync(cam2_vsync),
        .cam2_href (cam2_href ),
        .cam2_data (cam2_data ),
        .hdmi_de   (hdmi_de   ),
        .hdmi_r    (hdmi_r    ),
        .hdmi_g    (hdmi_g    ),
        .hdmi_b    (hdmi_b    ),
        .hdmi_hsync(hdmi_hsync),
        .hdmi_vsync(hdmi_vsync),
        .pix2      (pix2      ),
        .comb_err  (comb_err  ),
        .state     (state     )
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // each 565 field moves to the top of its 8-bit color
    function automatic logic [23:0] rgb_expand(input logic [15:0] p);
        return {p[15:11], 3'b000, p[10:5], 2'b00, p[4:0], 3'b000};
    endfunction

    function automatic logic [7:0] byte_of(input logic [15:0] p, input int idx);
        return idx[0] ? p[7:0] : p[15:8];
    endfunction

    assign idle_obs = {state, hdmi_de, hdmi_hsync, comb_err};
    assign hs_exp   = |fall_sr[hs_span-2:hs_after-1];

    // expected hsync comes from a delay line of cam1 href falling edges
    always @(posedge clk) begin
        if (rst) begin
            href_q  <= 1'b0;
            fall_sr <= '0;
        end else begin
            href_q  <= cam1_href;
            fall_sr <= {fall_sr[hs_span-2:0], href_q && !cam1_href};
        end
    end

    // pop one reference pair per displayed pixel, away from the clock edge
    always @(negedge clk) begin
        if (hdmi_de === 1'b1) begin
            have_ref = (ref1.size() > 0) && (ref2.size() > 0);
            if (have_ref) begin
                head1 = ref1.pop_front();
                head2 = ref2.pop_front();
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("run stopped after %0d cycles before the stimulus was done", cycles);
            $display("TEST FAILED");
            $finish;
        end
    end

    a_reset_state : assert property (@(posedge clk) idle_phase |-> idle_obs == idle_exp)
    else begin
        err_value++;
        $display("FAILED reset_state: expected %b actual %b", idle_exp, $sampled(idle_obs));
    end

    a_have_ref : assert property (@(posedge clk) disable iff (rst) hdmi_de |-> have_ref)
    else begin
        err_other++;
        $display("hdmi_de was high but no sent pixel was left to compare with");
    end

    a_cam1_color : assert property (
        @(posedge clk) disable iff (rst)
        hdmi_de && have_ref |-> {hdmi_r, hdmi_g, hdmi_b} == rgb_expand(head1)
    ) else begin
        err_value++;
        $display("FAILED color_pairing: expected %h actual %h", rgb_expand($sampled(head1)),
                 $sampled({hdmi_r, hdmi_g, hdmi_b}));
    end

    a_cam2_pixel : assert property (
        @(posedge clk) disable iff (rst)
        hdmi_de && have_ref |-> pix2 == head2
    ) else begin
        err_value++;
        $display("FAILED cam2_pairing: expected %h actual %h", $sampled(head2), $sampled(pix2));
    end

    a_hsync_timing : assert property (@(posedge clk) disable iff (rst) hdmi_hsync == hs_exp)
    else begin
        err_value++;
        $display("FAILED hsync_timing: expected %b actual %b", $sampled(hs_exp),
                 $sampled(hdmi_hsync));
    end

    // vsync of the first camera goes straight to the output
    a_vsync_pass : assert property (@(posedge clk) disable iff (rst) hdmi_vsync == cam1_vsync)
    else begin
        err_value++;
        $display("FAILED vsync_pass: expected %b actual %b", $sampled(cam1_vsync),
                 $sampled(hdmi_vsync));
    end

    a_clean_no_err : assert property (@(posedge clk) disable iff (rst) clean |-> !comb_err)
    else begin
        err_value++;
        $display("FAILED clean_frame: expected comb_err 0 actual %b", $sampled(comb_err));
    end

    // two cycles after the fault the pipeline has emptied, the output stays blank
    a_fault_blank : assert property (
        @(posedge clk) disable iff (rst)
        comb_err && $past(comb_err) && $past(comb_err, 2) |-> !hdmi_de
    ) else begin
        err_value++;
        $display("FAILED fault_blank: expected hdmi_de 0 actual %b", $sampled(hdmi_de));
    end

    a_fault_seen : assert property (@(posedge clk) disable iff (rst) fault_check |-> comb_err)
    else begin
        err_other++;
        $display("comb_err did not rise after the forced fault");
    end

    a_drained : assert property (
        @(posedge clk) disable iff (rst)
        drain_check |-> left1 == 0 && left2 == 0
    ) else begin
        err_other++;
        $display("sent pixels never reached the output (%0d and %0d left)", left1, left2);
    end

    task step;
        @(posedge clk);
        #10;
    endtask

    task next_rand(output logic [31:0] r);
        rnd = xorshift(rnd);
        r   = rnd;
    endtask

    task frame_start;
        cam1_vsync = 1'b1;
        cam2_vsync = 1'b1;
        ref1.delete();
        ref2.delete();
        repeat (4) step;
        cam1_vsync = 1'b0;
        cam2_vsync = 1'b0;
        repeat (4) step;
    endtask

    // cam2 starts skew cycles after cam1, lengths are in pixels
    task automatic send_line(input int len1, input int len2, input int skew);
        logic [15:0] p1 [$];
        logic [15:0] p2 [$];
        logic [31:0] r;
        int          total;
        int          i;
        int          k;
        for (i = 0; i < len1; i++) begin
            next_rand(r);
            p1.push_back(r[15:0]);
            ref1.push_back(r[15:0]);
            if (i < len2) begin
                p2.push_back(r[31:16]);
                ref2.push_back(r[31:16]);
            end
        end
        total = (2 * len1 > skew + 2 * len2) ? 2 * len1 : skew + 2 * len2;
        for (i = 0; i < total; i++) begin
            k         = i - skew;
            cam1_href = (i < 2 * len1);
            cam2_href = (k >= 0) && (k < 2 * len2);
            cam1_data = 8'h00;
            cam2_data = 8'h00;
            if (cam1_href) begin
                cam1_data = byte_of(p1[i / 2], i);
            end
            if (cam2_href) begin
                cam2_data = byte_of(p2[k / 2], k);
            end
            step;
        end
        cam1_href = 1'b0;
        cam2_href = 1'b0;
        cam1_data = 8'h00;
        cam2_data = 8'h00;
        repeat (12) step;
    endtask

    task automatic clean_line;
        logic [31:0] r;
        int          len;
        next_rand(r);
        len = 2 + int'(r[7:0]) % (max_pix - 1);
        send_line(len, len, int'(r[15:8]) % 11);
    endtask

    task automatic wait_drain;
        int n;
        n = 0;
        while ((ref1.size() != 0 || ref2.size() != 0) && n < 40) begin
            step;
            n++;
        end
        left1       = ref1.size();
        left2       = ref2.size();
        drain_check = 1'b1;
        step;
        drain_check = 1'b0;
    endtask

    task automatic wait_fault;
        int n;
        n = 0;
        while (comb_err !== 1'b1 && n < 60) begin
            step;
            n++;
        end
        fault_check = 1'b1;
        step;
        fault_check = 1'b0;
    endtask

    task automatic clean_frame;
        frame_start;
        clean = 1'b1;
        repeat (n_lines) clean_line;
        wait_drain;
    endtask

    initial begin
        logic [31:0] r;
        int          len;
        rst         = 1'b1;
        en          = 1'b0;
        cam1_vsync  = 1'b0;
        cam1_href   = 1'b0;
        cam1_data   = 8'h00;
        cam2_vsync  = 1'b0;
        cam2_href   = 1'b0;
        cam2_data   = 8'h00;
        have_ref    = 1'b0;
        idle_phase  = 1'b0;
        clean       = 1'b0;
        fault_check = 1'b0;
        drain_check = 1'b0;
        left1       = 0;
        left2       = 0;
        err_value   = 0;
        err_other   = 0;
        cycles      = 0;
        rnd         = 32'he832_af68;

        step;
        idle_phase = 1'b1; // reset has reached the registers by now
        repeat (2) step;
        rst = 1'b0;
        repeat (3) step;
        en         = 1'b1;
        idle_phase = 1'b0;
        step;

        clean_frame;
        clean_frame;

        // cam2 drops two pixels of one line
        frame_start;
        clean = 1'b1;
        clean_line;
        clean = 1'b0;
        next_rand(r);
        len = 4 + int'(r[7:0]) % (max_pix - 3);
        send_line(len, len - 2, int'(r[15:8]) % 11);
        wait_fault;
        clean_frame;

        // cam1 runs alone until its buffer spills
        clean = 1'b0;
        send_line(fifo_depth + 4, 0, 0);
        wait_fault;
        clean_frame;
        clean = 1'b0;

        $display("errors: %0d wrong values, %0d other failures", err_value, err_other);
        if (err_value + err_other == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule : tb_aimbot_vision

// ==== files.f ====
hw/aimbot_pkg.sv
hw/rgb565_capture.sv
hw/line_fifo.sv
hw/pixel_combine.sv
hw/hsync_gen.sv
hw/stream_ctrl.sv
hw/aimbot_vision.sv
tb/tb_aimbot_vision.sv
